/* rtl/umi_cmd_pkg.sv */
`default_nettype none

// command field encodings for the packet memory interface
package umi_cmd_pkg;

   // 7-bit command, [2:0] low code, [6:3] high code
   typedef logic [6:0] cmd_t;

   // low code of a write command
   typedef logic [2:0] wr_code_t;

   // high code of an atomic, selects the operation
   typedef logic [3:0] atom_code_t;

   // write kinds, codes 5..7 reserved
   localparam wr_code_t WR_NORMAL   = 3'd0; // posted
   localparam wr_code_t WR_RESPONSE = 3'd1; // response to an earlier write
   localparam wr_code_t WR_SIGNAL   = 3'd2; // posted, end of transfer
   localparam wr_code_t WR_STREAM   = 3'd3; // posted, streaming
   localparam wr_code_t WR_ACK      = 3'd4; // acknowledged write

   // atomic kinds, codes 9..15 reserved
   localparam atom_code_t ATOM_ADD  = 4'd0;
   localparam atom_code_t ATOM_AND  = 4'd1;
   localparam atom_code_t ATOM_OR   = 4'd2;
   localparam atom_code_t ATOM_XOR  = 4'd3;
   localparam atom_code_t ATOM_MAX  = 4'd4; // signed
   localparam atom_code_t ATOM_MIN  = 4'd5; // signed
   localparam atom_code_t ATOM_MAXU = 4'd6;
   localparam atom_code_t ATOM_MINU = 4'd7;
   localparam atom_code_t ATOM_SWAP = 4'd8; // highest legal kind

   // low code that turns a non-write into an atomic
   localparam logic [2:0] ATOM_LOW_CODE = 3'd2;

endpackage

`default_nettype wire

/* rtl/umi_decode.sv */
`default_nettype none
`timescale 1ns/1ps

// sorts a command into its request class, purely combinational
module umi_decode
   import umi_cmd_pkg::*;
(
   input  cmd_t       command,
   input  logic       write,
   output logic       cmd_invalid,        // all-zero command
   output logic       cmd_read,           // any valid non-write
   output logic       cmd_atomic,         // read-modify-write
   output logic       cmd_write_normal,
   output logic       cmd_write_response,
   output logic       cmd_write_signal,
   output logic       cmd_write_stream,
   output logic       cmd_write_ack,
   output atom_code_t atom_kind,          // high code, meaningful for atomics
   output logic       atom_valid          // kind within the defined set
);

   wr_code_t low_code;

   assign low_code = command[2:0];

   // grouping
   assign cmd_invalid = ~|command;
   assign cmd_read    = ~write & ~cmd_invalid;
   assign cmd_atomic  = cmd_read & (low_code == ATOM_LOW_CODE);

   // write kinds, 5..7 match nothing
   assign cmd_write_normal   = write & (low_code == WR_NORMAL);
   assign cmd_write_response = write & (low_code == WR_RESPONSE);
   assign cmd_write_signal   = write & (low_code == WR_SIGNAL);
   assign cmd_write_stream   = write & (low_code == WR_STREAM);
   assign cmd_write_ack      = write & (low_code == WR_ACK);

   // atomic kind passed on as a code instead of one-hot lines
   assign atom_kind  = command[6:3];
   assign atom_valid = (atom_kind <= ATOM_SWAP); // swap is the last one

endmodule

`default_nettype wire

/* rtl/umi_mem_endpoint.sv */
`default_nettype none
`timescale 1ns/1ps

// memory endpoint, request -> memory -> response
module umi_mem_endpoint
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
#(
   parameter int DEPTH_LOG2 = 6 // 64 words
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  req_valid,
   output logic  req_ready,
   input  cmd_t  req_cmd,
   input  logic  req_write,
   input  addr_t req_addr,
   input  data_t req_data,
   output logic  resp_valid,
   input  logic  resp_ready,
   output data_t resp_data,
   output logic  resp_ack,
   output logic  resp_err
);

   // request stage to memory stage
   logic       rq_valid;
   logic       rq_ready;
   addr_t      rq_addr;
   data_t      rq_data;
   logic       rq_read;
   logic       rq_atomic;
   atom_code_t rq_kind;
   logic       rq_write;
   logic       rq_posted;
   logic       rq_ack_write;
   logic       rq_bad;

   // memory stage to response stage
   logic       mm_valid;
   logic       mm_ready;
   data_t      mm_result;
   logic       mm_needs_resp;
   logic       mm_ack;
   logic       mm_err;

   umi_req_stage u_req (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (req_valid),
      .in_ready     (req_ready),
      .cmd          (req_cmd),
      .write        (req_write),
      .addr         (req_addr),
      .data         (req_data),
      .out_valid    (rq_valid),
      .out_ready    (rq_ready),
      .out_addr     (rq_addr),
      .out_data     (rq_data),
      .is_read      (rq_read),
      .is_atomic    (rq_atomic),
      .is_write     (rq_write),
      .is_posted    (rq_posted),
      .is_ack_write (rq_ack_write),
      .is_bad       (rq_bad),
      .atom_kind    (rq_kind)
   );

   umi_mem_stage #(
      .DEPTH_LOG2 (DEPTH_LOG2)
   ) u_mem (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (rq_valid),
      .in_ready     (rq_ready),
      .addr         (rq_addr),
      .data         (rq_data),
      .is_read      (rq_read),
      .is_atomic    (rq_atomic),
      .atom_kind    (rq_kind),
      .is_write     (rq_write),
      .is_posted    (rq_posted),
      .is_ack_write (rq_ack_write),
      .is_bad       (rq_bad),
      .out_valid    (mm_valid),
      .out_ready    (mm_ready),
      .result       (mm_result),
      .needs_resp   (mm_needs_resp),
      .ack          (mm_ack),
      .err          (mm_err)
   );

   umi_resp_stage u_resp (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (mm_valid),
      .in_ready   (mm_ready),
      .result     (mm_result),
      .needs_resp (mm_needs_resp),
      .ack        (mm_ack),
      .err        (mm_err),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_data  (resp_data),
      .resp_ack   (resp_ack),
      .resp_err   (resp_err)
   );

endmodule

`default_nettype wire

/* rtl/umi_mem_pkg.sv */
`default_nettype none

// word types on the memory side
package umi_mem_pkg;

   // one data word, no byte lanes
   typedef logic [31:0] data_t;

   // word address, not a byte address
   // upper bits beyond the array depth must be zero
   typedef logic [31:0] addr_t;

endpackage

`default_nettype wire

/* rtl/umi_mem_stage.sv */
`default_nettype none
`timescale 1ns/1ps

// word memory with atomic ALU, access happens on the load edge
module umi_mem_stage
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
#(
   parameter int DEPTH_LOG2 = 6 // address bits that pick a word
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_valid,
   output logic       in_ready,
   input  addr_t      addr,
   input  data_t      data,
   input  logic       is_read,
   input  logic       is_atomic,
   input  atom_code_t atom_kind,
   input  logic       is_write,
   input  logic       is_posted,
   input  logic       is_ack_write,
   input  logic       is_bad,
   output logic       out_valid,
   input  logic       out_ready,
   output data_t      result,
   output logic       needs_resp,
   output logic       ack,
   output logic       err
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   data_t                 mem [DEPTH];
   logic [DEPTH_LOG2-1:0] word_idx;
   logic                  out_of_range;
   logic                  err_now;
   logic                  in_fire;
   logic                  do_store;
   data_t                 old_word;  // value before this access
   data_t                 atom_word; // value an atomic leaves behind
   data_t                 store_word;

   assign word_idx     = addr[DEPTH_LOG2-1:0];
   assign out_of_range = |(addr >> DEPTH_LOG2); // any bit above the array
   assign err_now      = is_bad | out_of_range;
   assign old_word     = mem[word_idx];

   assign in_ready = ~out_valid | out_ready;
   assign in_fire  = in_valid & in_ready;

   // atomic ALU
   always_comb begin
      case (atom_kind)
         ATOM_ADD:  atom_word = old_word + data; // wraps
         ATOM_AND:  atom_word = old_word & data;
         ATOM_OR:   atom_word = old_word | data;
         ATOM_XOR:  atom_word = old_word ^ data;
         ATOM_MAX:  atom_word = ($signed(data) > $signed(old_word)) ? data : old_word;
         ATOM_MIN:  atom_word = ($signed(data) < $signed(old_word)) ? data : old_word;
         ATOM_MAXU: atom_word = (data > old_word) ? data : old_word;
         ATOM_MINU: atom_word = (data < old_word) ? data : old_word;
         ATOM_SWAP: atom_word = data;
         default:   atom_word = old_word; // reserved, flagged bad upstream
      endcase
   end

   // errored items never touch the array
   assign do_store   = in_fire & ~err_now & (is_write | is_atomic);
   assign store_word = is_atomic ? atom_word : data;

   always_ff @(posedge clk) begin
      if (do_store) begin
         mem[word_idx] <= store_word;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (in_fire) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         // reads and atomics hand back the old word
         result     <= (is_read | is_atomic) ? old_word : '0;
         needs_resp <= ~(is_posted & ~err_now); // posted writes stay silent
         ack        <= is_ack_write & ~err_now;
         err        <= err_now;
      end
   end

endmodule

`default_nettype wire

/* rtl/umi_req_stage.sv */
`default_nettype none
`timescale 1ns/1ps

// input slot, holds one request with its decoded class
module umi_req_stage
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_valid,
   output logic       in_ready,
   input  cmd_t       cmd,
   input  logic       write,
   input  addr_t      addr,
   input  data_t      data,
   output logic       out_valid,
   input  logic       out_ready,
   output addr_t      out_addr,
   output data_t      out_data,
   output logic       is_read,
   output logic       is_atomic,
   output logic       is_write,
   output logic       is_posted,
   output logic       is_ack_write,
   output logic       is_bad,
   output atom_code_t atom_kind
);

   logic       dec_invalid;
   logic       dec_read;
   logic       dec_atomic;
   logic       dec_normal;
   logic       dec_response;
   logic       dec_signal;
   logic       dec_stream;
   logic       dec_ack;
   atom_code_t dec_kind;
   logic       dec_kind_ok;
   logic       dec_reserved; // write with codes 5..7
   logic       dec_posted;
   logic       in_fire;

   umi_decode u_decode (
      .command            (cmd),
      .write              (write),
      .cmd_invalid        (dec_invalid),
      .cmd_read           (dec_read),
      .cmd_atomic         (dec_atomic),
      .cmd_write_normal   (dec_normal),
      .cmd_write_response (dec_response),
      .cmd_write_signal   (dec_signal),
      .cmd_write_stream   (dec_stream),
      .cmd_write_ack      (dec_ack),
      .atom_kind          (dec_kind),
      .atom_valid         (dec_kind_ok)
   );

   assign dec_posted   = dec_normal | dec_signal | dec_stream;
   assign dec_reserved = write & ~(dec_posted | dec_response | dec_ack);

   // slot free, or its item leaves this cycle
   assign in_ready = ~out_valid | out_ready;
   assign in_fire  = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (in_fire) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0; // drained
      end
   end

   // payload and class flags, no reset
   always_ff @(posedge clk) begin
      if (in_fire) begin
         out_addr     <= addr;
         out_data     <= data;
         is_read      <= dec_read & ~dec_atomic; // plain read only
         is_atomic    <= dec_atomic;
         atom_kind    <= dec_kind;
         is_posted    <= dec_posted;
         is_write     <= dec_posted | dec_ack;
         is_ack_write <= dec_ack;
         // nothing this endpoint can serve
         is_bad       <= dec_invalid | dec_response | dec_reserved
                         | (dec_atomic & ~dec_kind_ok);
      end
   end

endmodule

`default_nettype wire

/* rtl/umi_resp_stage.sv */
`default_nettype none
`timescale 1ns/1ps

// output slot, drops posted writes and presents responses
module umi_resp_stage
   import umi_mem_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_valid,
   output logic  in_ready,
   input  data_t result,
   input  logic  needs_resp,
   input  logic  ack,
   input  logic  err,
   output logic  resp_valid,
   input  logic  resp_ready,
   output data_t resp_data,
   output logic  resp_ack,
   output logic  resp_err
);

   logic in_fire;

   assign in_ready = ~resp_valid | resp_ready;
   assign in_fire  = in_valid & in_ready;

   // every item is taken, only the ones that answer occupy the slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
      end else if (in_fire) begin
         resp_valid <= needs_resp; // posted write consumed here
      end else if (resp_ready) begin
         resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         resp_data <= (ack | err) ? '0 : result; // no payload on acks and errors
         resp_ack  <= ack;
         resp_err  <= err;
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the memory endpoint testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
   --top-module tb_umi_mem_endpoint -f sim.f

./obj_dir/Vtb_umi_mem_endpoint > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
echo "simulation PASSED"

/* sim.f */
rtl/umi_cmd_pkg.sv
rtl/umi_mem_pkg.sv
rtl/umi_decode.sv
rtl/umi_req_stage.sv
rtl/umi_mem_stage.sv
rtl/umi_resp_stage.sv
rtl/umi_mem_endpoint.sv
verification/tb_clk_gen.sv
verification/tb_umi_mem_endpoint.sv

/* verification/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

// free running testbench clock
module tb_clk_gen #(
   parameter int PERIOD_NS = 20
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk; // 50 % duty
   end

endmodule

`default_nettype wire

/* verification/tb_umi_mem_endpoint.sv */
`default_nettype none
`timescale 1ns/1ps

// endpoint testbench, reference memory plus ordered response checks
module tb_umi_mem_endpoint
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
();

   localparam int   DEPTH_LOG2 = 6;
   localparam int   WORDS      = 2 ** DEPTH_LOG2;
   localparam int   N_RANDOM   = 400;
   localparam int   N_DIRECTED = 2 * WORDS + 27 + 33; // fill, readback, atomics, errors
   localparam int   WD_CYCLES  = (N_DIRECTED + N_RANDOM) * 50 + 200;
   localparam cmd_t READ_CMD   = 7'h01;

   logic  clk;
   logic  rst_n      = 1'b0;
   logic  req_valid  = 1'b0;
   logic  req_ready;
   cmd_t  req_cmd    = '0;
   logic  req_write  = 1'b0;
   addr_t req_addr   = '0;
   data_t req_data   = '0;
   logic  resp_valid;
   logic  resp_ready = 1'b1;
   data_t resp_data;
   logic  resp_ack;
   logic  resp_err;

   data_t       ref_mem [WORDS]; // model of the array
   logic [33:0] exp_q [$];       // {err, ack, data} in request order
   int          acc_q [$];       // acceptance cycle per entry
   int          cycle_cnt = 0;
   integer      seed      = 7278;
   logic        bp_on     = 1'b0; // random resp_ready
   logic        timing_on = 1'b0; // fixed latency expected

   // queue head, refreshed mid-cycle so the edge sees a stable copy
   logic  head_valid = 1'b0;
   data_t head_data  = '0;
   logic  head_ack   = 1'b0;
   logic  head_err   = 1'b0;
   int    head_cycle = 0;

   tb_clk_gen #(.PERIOD_NS (20)) u_clk (.clk (clk));

   umi_mem_endpoint #(
      .DEPTH_LOG2 (DEPTH_LOG2)
   ) u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_cmd    (req_cmd),
      .req_write  (req_write),
      .req_addr   (req_addr),
      .req_data   (req_data),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_data  (resp_data),
      .resp_ack   (resp_ack),
      .resp_err   (resp_err)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input data_t exp, input data_t act);
      abort_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   function automatic data_t fill_word(input int a);
      return (data_t'(a) + 32'd1) * 32'h9E37_79B9 ^ 32'h0F1E_2D3C; // whole address mixed in
   endfunction

   function automatic cmd_t wr_cmd(input wr_code_t code);
      return {4'd1, code}; // nonzero high code, else the command reads as invalid
   endfunction

   // expected new word of a read-modify-write
   function automatic data_t atom_expect(input atom_code_t kind, input data_t old,
                                         input data_t opnd);
      case (kind)
         ATOM_ADD:  return old + opnd;
         ATOM_AND:  return old & opnd;
         ATOM_OR:   return old | opnd;
         ATOM_XOR:  return old ^ opnd;
         ATOM_MAX:  return ($signed(old) < $signed(opnd)) ? opnd : old;
         ATOM_MIN:  return ($signed(opnd) < $signed(old)) ? opnd : old;
         ATOM_MAXU: return (old < opnd) ? opnd : old;
         ATOM_MINU: return (opnd < old) ? opnd : old;
         default:   return opnd; // swap
      endcase
   endfunction

   // {stored word, operand}, picked so signed and unsigned picks differ
   function automatic logic [63:0] atom_operands(input atom_code_t kind);
      case (kind)
         ATOM_ADD:  return {32'hFFFF_FFF0, 32'h0000_0020}; // wraps past zero
         ATOM_AND:  return {32'hF0F0_1234, 32'h0FF0_FF00};
         ATOM_OR:   return {32'h1200_0034, 32'h0045_6700};
         ATOM_XOR:  return {32'hA5A5_A5A5, 32'hFFFF_0000};
         ATOM_MAX:  return {32'h7FFF_FFFF, 32'h8000_0000};
         ATOM_MIN:  return {32'h0000_0001, 32'h8000_0000};
         ATOM_MAXU: return {32'h7FFF_FFFF, 32'h8000_0000};
         ATOM_MINU: return {32'h0000_0001, 32'hFFFF_FFFF};
         default:   return {32'hDEAD_BEEF, 32'h1234_5678};
      endcase
   endfunction

   // applies one accepted request to the model, queues its answer
   task automatic model_request(input cmd_t cmd, input logic wr, input addr_t addr,
                                input data_t data);
      logic       bad;
      logic       silent;
      logic       is_ack;
      data_t      word;
      wr_code_t   low;
      atom_code_t kind;
      low    = cmd[2:0];
      kind   = cmd[6:3];
      bad    = (cmd == '0) || (addr >= addr_t'(WORDS));
      silent = 1'b0;
      is_ack = 1'b0;
      word   = '0;
      if (wr) begin
         if (low == WR_ACK) begin
            is_ack = 1'b1;
         end else if (low == WR_NORMAL || low == WR_SIGNAL || low == WR_STREAM) begin
            silent = 1'b1;
         end else begin
            bad = 1'b1; // write response and codes 5..7
         end
      end else if (low == ATOM_LOW_CODE && kind > ATOM_SWAP) begin
         bad = 1'b1;
      end
      if (bad) begin
         silent = 1'b0;
         is_ack = 1'b0; // error answers carry no ack
      end else if (wr) begin
         ref_mem[addr[DEPTH_LOG2-1:0]] = data;
      end else begin
         word = ref_mem[addr[DEPTH_LOG2-1:0]]; // old word for atomics too
         if (low == ATOM_LOW_CODE) begin
            ref_mem[addr[DEPTH_LOG2-1:0]] = atom_expect(kind, word, data);
         end
      end
      if (!silent) begin
         exp_q.push_back({bad, is_ack, word});
         acc_q.push_back(cycle_cnt);
      end
   endtask

   // holds the request until the handshake edge
   task automatic send_req(input cmd_t cmd, input logic wr, input addr_t addr,
                           input data_t data);
      req_valid <= 1'b1;
      req_cmd   <= cmd;
      req_write <= wr;
      req_addr  <= addr;
      req_data  <= data;
      @(posedge clk);
      while (!req_ready) begin
         @(posedge clk);
      end
      req_valid <= 1'b0;
   endtask

   // mostly legal mix, one in eight commands fully random
   task automatic send_random();
      logic [31:0] r;
      cmd_t        cmd;
      addr_t       addr;
      r = $random(seed);
      if (r[3:1] == 3'd0) begin
         cmd = r[10:4];
      end else if (r[0]) begin
         cmd = wr_cmd((r[16:15] == 2'd1) ? WR_ACK : {1'b0, r[16:15]});
      end else if (r[11]) begin
         cmd = READ_CMD;
      end else begin
         cmd = {r[15:12], ATOM_LOW_CODE}; // kinds 9..15 come out as errors
      end
      addr = (r[20:17] == 4'd0) ? {16'd1, r[31:16]} : {28'd0, r[24:21]};
      send_req(cmd, r[0], addr, $random(seed));
   endtask

   task automatic check_idle_ports();
      assert (!resp_valid) else report_mismatch("resp_valid", 32'd0, data_t'(resp_valid));
      assert (req_ready) else report_mismatch("req_ready", 32'd1, data_t'(req_ready));
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (rst_n) begin
         if (resp_valid && resp_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front()); // retired, checked by the assertions below
            void'(acc_q.pop_front());
         end
         if (req_valid && req_ready) begin
            model_request(req_cmd, req_write, req_addr, req_data);
         end
      end
   end

   always @(negedge clk) begin
      head_valid = (exp_q.size() > 0);
      if (head_valid) begin
         {head_err, head_ack, head_data} = exp_q[0];
         head_cycle = acc_q[0];
      end
   end

   // random stalls on the response side
   always @(posedge clk) begin
      logic [31:0] r;
      r = $random(seed);
      resp_ready <= bp_on ? r[0] : 1'b1;
   end

   a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && resp_ready |-> head_valid)
      else abort_run($sformatf("response at %0t with no request outstanding", $time));
   a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && resp_ready && head_valid |-> resp_data == head_data)
      else report_mismatch("resp_data", head_data, $sampled(resp_data));
   a_resp_ack: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && resp_ready && head_valid |-> resp_ack == head_ack)
      else report_mismatch("resp_ack", data_t'(head_ack), data_t'($sampled(resp_ack)));
   a_resp_err: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && resp_ready && head_valid |-> resp_err == head_err)
      else report_mismatch("resp_err", data_t'(head_err), data_t'($sampled(resp_err)));
   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && resp_ready && head_valid && timing_on |-> cycle_cnt - head_cycle == 3)
      else report_mismatch("response latency", 32'd3,
                           data_t'($sampled(cycle_cnt) - head_cycle));

   initial begin
      logic [63:0] ops;
      repeat (9) begin
         @(posedge clk);
         @(negedge clk);
         check_idle_ports();
      end
      @(posedge clk);
      rst_n     <= 1'b1; // tenth reset edge
      timing_on <= 1'b1;
      @(negedge clk);
      check_idle_ports(); // first cycle out of reset
      @(posedge clk);

      // fill every word, rotating through the accepted write kinds
      for (int a = 0; a < WORDS; a++) begin
         case (a[1:0])
            2'd0:    send_req(wr_cmd(WR_NORMAL), 1'b1, addr_t'(a), fill_word(a));
            2'd1:    send_req(wr_cmd(WR_SIGNAL), 1'b1, addr_t'(a), fill_word(a));
            2'd2:    send_req(wr_cmd(WR_STREAM), 1'b1, addr_t'(a), fill_word(a));
            default: send_req(wr_cmd(WR_ACK), 1'b1, addr_t'(a), fill_word(a));
         endcase
      end
      for (int a = 0; a < WORDS; a++) begin
         send_req(READ_CMD, 1'b0, addr_t'(a), '0);
      end

      // each atomic kind: seed the word, modify it, read it back
      for (int k = 0; k <= 8; k++) begin
         ops = atom_operands(atom_code_t'(k));
         send_req(wr_cmd(WR_NORMAL), 1'b1, addr_t'(k), ops[63:32]);
         send_req({atom_code_t'(k), ATOM_LOW_CODE}, 1'b0, addr_t'(k), ops[31:0]);
         send_req(READ_CMD, 1'b0, addr_t'(k), '0);
      end

      // error cases, none may touch the array
      send_req(7'h00, 1'b0, addr_t'(1), '0);
      send_req(7'h00, 1'b1, addr_t'(2), 32'h1111_1111); // all-zero write command
      send_req(wr_cmd(WR_RESPONSE), 1'b1, addr_t'(3), 32'h2222_2222);
      for (int c = 5; c <= 7; c++) begin
         send_req(wr_cmd(wr_code_t'(c)), 1'b1, addr_t'(c), 32'h3333_3333);
      end
      for (int k = 9; k <= 15; k++) begin
         send_req({atom_code_t'(k), ATOM_LOW_CODE}, 1'b0, addr_t'(k - 8), 32'h4444_4444);
      end
      send_req(READ_CMD, 1'b0, 32'd64, '0);
      send_req(wr_cmd(WR_ACK), 1'b1, 32'd64, 32'h5555_5555);      // would alias word 0
      send_req(wr_cmd(WR_NORMAL), 1'b1, 32'h8000_0000, 32'h6666_6666);
      send_req({ATOM_ADD, ATOM_LOW_CODE}, 1'b0, 32'h0000_0100, 32'd1);
      for (int a = 0; a < 16; a++) begin
         send_req(READ_CMD, 1'b0, addr_t'(a), '0);
      end

      // random traffic with stalls on both sides
      bp_on     <= 1'b1;
      timing_on <= 1'b0;
      for (int n = 0; n < N_RANDOM; n++) begin
         while ($random(seed) % 4 == 0) begin
            req_valid <= 1'b0; // idle cycle
            @(posedge clk);
         end
         send_random();
      end

      req_valid <= 1'b0;
      bp_on     <= 1'b0;
      for (int w = 0; w < 100 && exp_q.size() != 0; w++) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk); // time for a stray response to show
      if (exp_q.size() != 0) begin
         abort_run($sformatf("%0d expected responses never arrived", exp_q.size()));
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

   // watchdog, 50 cycles per request plus margin
   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      abort_run("timeout, responses stopped arriving");
   end

endmodule

`default_nettype wire
